// File: Bender.yml
package:
  name: tapnw

sources:
  # rtl in compile order
  - src/tapnw_pkg.sv
  - src/tap_controller.sv
  - src/tap_data_reg.sv
  - src/master_tap.sv
  - src/slave_tap.sv
  - src/tapnw_top.sv
  # testbench and bound assertions
  - target: test
    files:
      - bench/tapnw_assertions.sv
      - bench/tapnw_tb.sv

// File: bench/tapnw_assertions.sv
// ==============================
// concurrent checks on the tap network, bound into tapnw_top
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tapnw_assertions (
  input wire logic                 tck,
  input wire logic                 rst_n,
  input wire logic                 tdo,
  input wire logic                 tdo_en,
  input wire tapnw_pkg::sel_t      slave_enable,
  input wire tapnw_pkg::tap_state_e master_state,
  input wire tapnw_pkg::tap_state_e slave0_state,
  input wire tapnw_pkg::tap_state_e slave1_state,
  input wire tapnw_pkg::tap_state_e slave2_state
);

  // read by the testbench at the end of the run
  int fail_count;

  initial fail_count = 0;

  // tdo_en follows the master shift states, half a cycle late
  a_tdo_en_shift: assert property (@(posedge tck) disable iff (!rst_n)
    tdo_en |-> master_state inside {tapnw_pkg::SHIFT_IR, tapnw_pkg::SHIFT_DR})
    else begin
      $error("tdo_en high outside a master shift state");
      fail_count++;
    end

  // parked one edge after the enable drops
  a_slave0_parked: assert property (@(posedge tck) disable iff (!rst_n)
    (!slave_enable[0] && $past(!slave_enable[0])) |-> slave0_state == tapnw_pkg::TEST_LOGIC_RESET)
    else begin
      $error("excluded slave 0 left test-logic-reset");
      fail_count++;
    end

  a_slave1_parked: assert property (@(posedge tck) disable iff (!rst_n)
    (!slave_enable[1] && $past(!slave_enable[1])) |-> slave1_state == tapnw_pkg::TEST_LOGIC_RESET)
    else begin
      $error("excluded slave 1 left test-logic-reset");
      fail_count++;
    end

  a_slave2_parked: assert property (@(posedge tck) disable iff (!rst_n)
    (!slave_enable[2] && $past(!slave_enable[2])) |-> slave2_state == tapnw_pkg::TEST_LOGIC_RESET)
    else begin
      $error("excluded slave 2 left test-logic-reset");
      fail_count++;
    end

  // loaded in run-test/idle, cleared in test-logic-reset
  a_enable_from_idle: assert property (@(posedge tck) disable iff (!rst_n)
    $changed(slave_enable) |->
      $past(master_state) inside {tapnw_pkg::RUN_TEST_IDLE, tapnw_pkg::TEST_LOGIC_RESET})
    else begin
      $error("slave_enable changed outside run-test/idle");
      fail_count++;
    end

  a_tdo_quiet: assert property (@(posedge tck) disable iff (!rst_n)
    !tdo_en |-> !tdo)
    else begin
      $error("tdo high while tdo_en is low");
      fail_count++;
    end

endmodule

bind tapnw_top tapnw_assertions u_assertions (
  .tck          (tck),
  .rst_n        (rst_n),
  .tdo          (tdo),
  .tdo_en       (tdo_en),
  .slave_enable (slave_enable),
  .master_state (u_master.state),
  .slave0_state (gen_slave[0].u_slave.u_ctrl.state),
  .slave1_state (gen_slave[1].u_slave.u_ctrl.state),
  .slave2_state (gen_slave[2].u_slave.u_ctrl.state)
);

`default_nettype wire

// File: bench/tapnw_tb.sv
// ==============================
// table-driven testbench for the jtag tap network, drives tck/tms/tdi
// and checks every scan against a small chain model
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tapnw_tb;

  localparam int PERIOD = 8;
  localparam int NUM_ROWS = 10;
  // extra bits past the chain end expose its length
  localparam int EXTRA = 8;
  localparam logic [7:0] TAIL = 8'ha6;
  localparam int VEC_W = 160;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;

  typedef logic [VEC_W-1:0] vec_t;

  typedef struct {
    string           name;
    tapnw_pkg::sel_t mask;
    tapnw_pkg::ir_t  opcode;
    logic [31:0]     pattern;
    bit              rand_data;
    bit              readback;
    bit              mid_reset;
  } row_t;

  logic tck;
  logic rst_n;
  logic tms;
  logic tdi;
  logic tdo;
  logic tdo_en;

  row_t        rows [NUM_ROWS];
  logic [31:0] rng;
  int          checks;
  int          errors;

  // tdo_en seen with the last tdo bit
  logic en_seen;
  // tdo_en per shifted bit, plus the exit1 cycle on top
  vec_t en_bits;

  // model of the network
  tapnw_pkg::ir_t   m_ir;
  tapnw_pkg::sel_t  m_sel;
  tapnw_pkg::sel_t  m_en;
  tapnw_pkg::ir_t   s_ir [tapnw_pkg::NUM_SLAVES];
  tapnw_pkg::user_t s_user [tapnw_pkg::NUM_SLAVES];

  tapnw_top dut (
    .tck    (tck),
    .rst_n  (rst_n),
    .tms    (tms),
    .tdi    (tdi),
    .tdo    (tdo),
    .tdo_en (tdo_en)
  );

  always #(PERIOD / 2) tck = ~tck;

  // ==============================
  // jtag driver
  // ==============================
  // entered 1 ns after a rising edge, tdo read before the next one
  task automatic clock_bit(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tms = tms_v;
    tdi = tdi_v;
    @(negedge tck);
    #2;
    tdo_v = tdo;
    en_seen = tdo_en;
    @(posedge tck);
    #1;
  endtask

  // third low cycle lets newly enabled slaves leave reset with the master
  task automatic goto_idle();
    logic unused;
    repeat (3) clock_bit(1'b0, 1'b0, unused);
  endtask

  // from shift state, n bits lsb first, then update and back to idle
  task automatic shift_bits(input vec_t data, input int n, output vec_t cap);
    logic bit_out;
    cap = '0;
    en_bits = '0;
    for (int k = 0; k < n; k++) begin
      clock_bit(k == n - 1, data[k], bit_out);
      cap[k] = bit_out;
      en_bits[k] = en_seen;
    end
    clock_bit(1'b1, 1'b0, bit_out);
    en_bits[n] = en_seen;
    goto_idle();
  endtask

  task automatic scan_ir(input vec_t data, input int n, output vec_t cap);
    logic unused;
    // select-dr, select-ir, capture-ir, shift-ir
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    shift_bits(data, n, cap);
  endtask

  task automatic scan_dr(input vec_t data, input int n, output vec_t cap);
    logic unused;
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    shift_bits(data, n, cap);
  endtask

  task automatic reset_by_tms();
    logic unused;
    repeat (5) clock_bit(1'b1, 1'b0, unused);
    reset_view();
    goto_idle();
  endtask

  // ==============================
  // reference model
  // ==============================
  task automatic reset_view();
    m_ir  = tapnw_pkg::OP_IDCODE;
    m_sel = '0;
    m_en  = '0;
    for (int i = 0; i < tapnw_pkg::NUM_SLAVES; i++) begin
      s_ir[i]   = tapnw_pkg::OP_IDCODE;
      s_user[i] = '0;
    end
  endtask

  // position 0 is the master, p is slave p-1
  function automatic bit tap_included(input int p);
    if (p == 0) begin
      return 1'b1;
    end
    return m_en[p-1];
  endfunction

  task automatic tap_register(input bit is_ir, input int p, output vec_t val, output int len);
    val = '0;
    len = 1;
    if (is_ir) begin
      val = tapnw_pkg::IR_CAPTURE;
      len = tapnw_pkg::IR_LEN;
    end else if (p == 0) begin
      if (m_ir == tapnw_pkg::OP_IDCODE) begin
        val = tapnw_pkg::MASTER_IDCODE;
        len = 32;
      end else if (m_ir == tapnw_pkg::OP_SELECT) begin
        val = m_sel;
        len = tapnw_pkg::NUM_SLAVES;
      end
    end else if (s_ir[p-1] == tapnw_pkg::OP_IDCODE) begin
      val = tapnw_pkg::SLAVE_IDCODE[p-1];
      len = 32;
    end else if (s_ir[p-1] == tapnw_pkg::OP_USER) begin
      val = s_user[p-1];
      len = 8;
    end
  endtask

  // last enabled tap sits in the lsbs, master on top
  task automatic model_capture(input bit is_ir, output vec_t cap, output int len);
    vec_t part;
    int   plen;
    cap = '0;
    len = 0;
    for (int p = tapnw_pkg::NUM_SLAVES; p >= 0; p--) begin
      if (tap_included(p)) begin
        tap_register(is_ir, p, part, plen);
        cap = cap | (part << len);
        len += plen;
      end
    end
  endtask

  task automatic model_update(input bit is_ir, input vec_t contents);
    vec_t part;
    int   plen;
    int   pos;
    pos = 0;
    for (int p = tapnw_pkg::NUM_SLAVES; p >= 0; p--) begin
      if (tap_included(p)) begin
        tap_register(is_ir, p, part, plen);
        part = contents >> pos;
        if (is_ir && p == 0) begin
          m_ir = tapnw_pkg::ir_t'(part);
        end else if (is_ir) begin
          s_ir[p-1] = tapnw_pkg::ir_t'(part);
        end else if (p == 0 && m_ir == tapnw_pkg::OP_SELECT) begin
          m_sel = tapnw_pkg::sel_t'(part);
        end else if (p != 0 && s_ir[p-1] == tapnw_pkg::OP_USER) begin
          s_user[p-1] = tapnw_pkg::user_t'(part);
        end
        pos += plen;
      end
    end
  endtask

  // excluded slaves sit in test-logic-reset and lose their state
  task automatic sync_enables();
    m_en = m_sel;
    for (int i = 0; i < tapnw_pkg::NUM_SLAVES; i++) begin
      if (!m_en[i]) begin
        s_ir[i]   = tapnw_pkg::OP_IDCODE;
        s_user[i] = '0;
      end
    end
  endtask

  // master opcode in the top group, one slave opcode per enabled slave below
  function automatic vec_t ir_groups(input tapnw_pkg::ir_t master_op,
                                     input tapnw_pkg::ir_t slave_op);
    vec_t v;
    int   k;
    v = '0;
    k = $countones(m_en);
    for (int g = 0; g < k; g++) begin
      v = v | (vec_t'(slave_op) << (tapnw_pkg::IR_LEN * g));
    end
    v = v | (vec_t'(master_op) << (tapnw_pkg::IR_LEN * k));
    return v;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic vec_t fill(input logic [31:0] pattern, input bit rand_data);
    vec_t v;
    for (int w = 0; w < VEC_W / 32; w++) begin
      if (rand_data) begin
        rng = xorshift32(rng);
        v[w*32 +: 32] = rng;
      end else begin
        v[w*32 +: 32] = pattern;
      end
    end
    return v;
  endfunction

  // ==============================
  // scan and compare
  // ==============================
  task automatic run_scan(input bit is_ir, input string name, input vec_t contents);
    vec_t cap_model;
    vec_t data;
    vec_t got;
    vec_t want;
    vec_t want_en;
    int   len;
    int   n;
    model_capture(is_ir, cap_model, len);
    n = len + EXTRA;
    contents = contents & ((vec_t'(1) << len) - 1);
    data = (contents << EXTRA) | vec_t'(TAIL);
    if (is_ir) begin
      scan_ir(data, n, got);
    end else begin
      scan_dr(data, n, got);
    end
    // capture values first, then the shifted data delayed by the chain length
    want = '0;
    for (int k = 0; k < n; k++) begin
      if (k < len) begin
        want[k] = cap_model[k];
      end else begin
        want[k] = data[k - len];
      end
    end
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h (%0d bits)", name, want, got, n);
    end
    // high on every shift bit, low again in exit1
    want_en = (vec_t'(1) << n) - 1;
    checks++;
    if (en_bits !== want_en) begin
      errors++;
      $display("ERROR %s tdo_en: expected %h, actual %h", name, want_en, en_bits);
    end
    model_update(is_ir, contents);
    sync_enables();
  endtask

  task automatic run_row(input row_t r);
    vec_t tmp;
    int   len;
    // master to select, slaves to bypass, then program the mask
    run_scan(1'b1, {r.name, "/sel_ir"}, ir_groups(tapnw_pkg::OP_SELECT, tapnw_pkg::OP_BYPASS));
    model_capture(1'b0, tmp, len);
    run_scan(1'b0, {r.name, "/sel_dr"}, vec_t'(r.mask) << (len - tapnw_pkg::NUM_SLAVES));
    run_scan(1'b1, {r.name, "/op_ir"}, ir_groups(r.opcode, r.opcode));
    run_scan(1'b0, {r.name, "/dr"}, fill(r.pattern, r.rand_data));
    if (r.readback) begin
      run_scan(1'b0, {r.name, "/readback"}, fill(r.pattern, r.rand_data));
    end
    if (r.mid_reset) begin
      reset_by_tms();
      run_scan(1'b0, {r.name, "/reset_dr"}, fill(r.pattern, 1'b0));
      run_scan(1'b1, {r.name, "/reset_ir"}, ir_groups(tapnw_pkg::OP_IDCODE, 0));
    end
  endtask

  task automatic load_table();
    rows[0] = '{"idcode_s0", 3'b001, tapnw_pkg::OP_IDCODE, 32'h0f0f_3c3c, 0, 0, 0};
    rows[1] = '{"idcode_all", 3'b111, tapnw_pkg::OP_IDCODE, 32'h9e37_79b9, 0, 0, 0};
    rows[2] = '{"idcode_s02", 3'b101, tapnw_pkg::OP_IDCODE, 32'h1234_5678, 0, 0, 0};
    rows[3] = '{"bypass_all", 3'b111, tapnw_pkg::OP_BYPASS, 32'hb5a5_c3e1, 0, 0, 0};
    // undecoded opcode behaves as bypass
    rows[4] = '{"other_op_s1", 3'b010, 4'h7, 32'h6d2b_79f5, 0, 0, 0};
    rows[5] = '{"user_all", 3'b111, tapnw_pkg::OP_USER, 32'h0, 1, 1, 0};
    rows[6] = '{"user_s12", 3'b110, tapnw_pkg::OP_USER, 32'h0, 1, 1, 0};
    // slave 0 comes back cleared
    rows[7] = '{"user_reenable", 3'b111, tapnw_pkg::OP_USER, 32'h0, 1, 1, 0};
    rows[8] = '{"mid_reset", 3'b011, tapnw_pkg::OP_USER, 32'h0, 1, 1, 1};
    rows[9] = '{"idcode_s2", 3'b100, tapnw_pkg::OP_IDCODE, 32'hc001_d00d, 0, 0, 0};
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    tck    = 1'b0;
    rst_n  = 1'b0;
    tms    = 1'b1;
    tdi    = 1'b0;
    rng    = 32'h55b6ead4;
    checks = 0;
    errors = 0;
    reset_view();
    load_table();
    repeat (4) @(posedge tck);
    #1;
    rst_n = 1'b1;
    goto_idle();
    // master alone after reset
    run_scan(1'b0, "reset_dr", fill(32'h3c5a_96e1, 1'b0));
    run_scan(1'b1, "reset_ir", ir_groups(tapnw_pkg::OP_IDCODE, 0));
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
             checks, errors, dut.u_assertions.fail_count);
    if (errors == 0 && dut.u_assertions.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog: no finish after %0d tck periods, the run looks hung", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/master_tap.sv
// ==============================
// master tap at the head of the chain, with ir, bypass, idcode and select
// drives one enable per slave, loaded only while in run-test/idle
// ==============================
`timescale 1ns/1ps
`default_nettype none

module master_tap (
  input  wire logic       tck,
  input  wire logic       rst_n,
  input  wire logic       tms,
  input  wire logic       tdi,
  output logic            so,
  output logic            shifting,
  output tapnw_pkg::sel_t slave_enable
);

  tapnw_pkg::tap_state_e state;
  logic                  capture_ir;
  logic                  shift_ir;
  logic                  update_ir;
  logic                  capture_dr;
  logic                  shift_dr;
  logic                  update_dr;
  logic                  test_reset;

  tapnw_pkg::ir_t        ir_shift;
  tapnw_pkg::ir_t        ir_q;
  logic [31:0]           idcode_shift;
  logic                  bypass_q;
  logic                  sel_idcode;
  logic                  sel_select;
  logic                  select_so;
  tapnw_pkg::sel_t       select_value;
  logic                  dr_so;

  // master is never excluded
  tap_controller u_ctrl (
    .tck        (tck),
    .rst_n      (rst_n),
    .tms        (tms),
    .hold_reset (1'b0),
    .state      (state),
    .capture_ir (capture_ir),
    .shift_ir   (shift_ir),
    .update_ir  (update_ir),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .update_dr  (update_dr),
    .test_reset (test_reset)
  );

  // ==============================
  // instruction register
  // ==============================
  always_ff @(posedge tck) begin
    if (capture_ir) begin
      ir_shift <= tapnw_pkg::IR_CAPTURE;
    end else if (shift_ir) begin
      ir_shift <= {tdi, ir_shift[tapnw_pkg::IR_LEN-1:1]};
    end
  end

  // idcode is the instruction after any reset
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      ir_q <= tapnw_pkg::OP_IDCODE;
    end else if (test_reset) begin
      ir_q <= tapnw_pkg::OP_IDCODE;
    end else if (update_ir) begin
      ir_q <= ir_shift;
    end
  end

  // everything else decodes as bypass
  assign sel_idcode = (ir_q == tapnw_pkg::OP_IDCODE);
  assign sel_select = (ir_q == tapnw_pkg::OP_SELECT);

  // ==============================
  // data registers
  // ==============================
  // idcode and bypass follow every dr scan, the mux picks one
  always_ff @(posedge tck) begin
    if (capture_dr) begin
      idcode_shift <= tapnw_pkg::MASTER_IDCODE;
      bypass_q     <= 1'b0;
    end else if (shift_dr) begin
      idcode_shift <= {tdi, idcode_shift[31:1]};
      bypass_q     <= tdi;
    end
  end

  tap_data_reg #(
    .payload_t (tapnw_pkg::sel_t)
  ) u_select (
    .tck     (tck),
    .rst_n   (rst_n),
    .clear   (test_reset),
    .capture (capture_dr & sel_select),
    .shift   (shift_dr & sel_select),
    .update  (update_dr & sel_select),
    .si      (tdi),
    .so      (select_so),
    .value   (select_value)
  );

  assign dr_so = sel_select ? select_so :
                 sel_idcode ? idcode_shift[0] : bypass_q;

  // falling edge launch, low outside the shift states
  always_ff @(negedge tck or negedge rst_n) begin
    if (!rst_n) begin
      so       <= 1'b0;
      shifting <= 1'b0;
    end else begin
      shifting <= shift_ir | shift_dr;
      if (shift_ir) begin
        so <= ir_shift[0];
      end else if (shift_dr) begin
        so <= dr_so;
      end else begin
        so <= 1'b0;
      end
    end
  end

  // slaves join or leave only from run-test/idle so they stay in step
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      slave_enable <= '0;
    end else if (test_reset) begin
      slave_enable <= '0;
    end else if (state == tapnw_pkg::RUN_TEST_IDLE) begin
      slave_enable <= select_value;
    end
  end

endmodule

`default_nettype wire

// File: src/slave_tap.sv
// ==============================
// one slave tap with ir, bypass, idcode and an 8-bit user register
// when not enabled it sits in reset and passes si straight to so
// ==============================
`timescale 1ns/1ps
`default_nettype none

module slave_tap #(
  // position on the chain, picks the idcode entry
  parameter int tap_index = 0
) (
  input  wire logic tck,
  input  wire logic rst_n,
  input  wire logic tms,
  input  wire logic enable,
  input  wire logic si,
  output logic      so
);

  logic              capture_ir;
  logic              shift_ir;
  logic              update_ir;
  logic              capture_dr;
  logic              shift_dr;
  logic              update_dr;
  logic              test_reset;

  tapnw_pkg::ir_t    ir_shift;
  tapnw_pkg::ir_t    ir_q;
  logic [31:0]       idcode_shift;
  logic              bypass_q;
  logic              sel_idcode;
  logic              sel_user;
  logic              user_so;
  logic              dr_so;
  logic              so_q;

  // excluded slave is pinned in test-logic-reset
  tap_controller u_ctrl (
    .tck        (tck),
    .rst_n      (rst_n),
    .tms        (tms),
    .hold_reset (~enable),
    .state      (),
    .capture_ir (capture_ir),
    .shift_ir   (shift_ir),
    .update_ir  (update_ir),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .update_dr  (update_dr),
    .test_reset (test_reset)
  );

  // ==============================
  // instruction register
  // ==============================
  always_ff @(posedge tck) begin
    if (capture_ir) begin
      ir_shift <= tapnw_pkg::IR_CAPTURE;
    end else if (shift_ir) begin
      ir_shift <= {si, ir_shift[tapnw_pkg::IR_LEN-1:1]};
    end
  end

  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      ir_q <= tapnw_pkg::OP_IDCODE;
    end else if (test_reset) begin
      ir_q <= tapnw_pkg::OP_IDCODE;
    end else if (update_ir) begin
      ir_q <= ir_shift;
    end
  end

  // user in place of select, rest is bypass
  assign sel_idcode = (ir_q == tapnw_pkg::OP_IDCODE);
  assign sel_user   = (ir_q == tapnw_pkg::OP_USER);

  // ==============================
  // data registers
  // ==============================
  always_ff @(posedge tck) begin
    if (capture_dr) begin
      idcode_shift <= tapnw_pkg::SLAVE_IDCODE[tap_index];
      bypass_q     <= 1'b0;
    end else if (shift_dr) begin
      idcode_shift <= {si, idcode_shift[31:1]};
      bypass_q     <= si;
    end
  end

  // reads back the last value written, lost whenever the slave leaves the chain
  tap_data_reg #(
    .payload_t (tapnw_pkg::user_t)
  ) u_user (
    .tck     (tck),
    .rst_n   (rst_n),
    .clear   (test_reset),
    .capture (capture_dr & sel_user),
    .shift   (shift_dr & sel_user),
    .update  (update_dr & sel_user),
    .si      (si),
    .so      (user_so),
    .value   ()
  );

  assign dr_so = sel_user   ? user_so :
                 sel_idcode ? idcode_shift[0] : bypass_q;

  always_ff @(negedge tck or negedge rst_n) begin
    if (!rst_n) begin
      so_q <= 1'b0;
    end else if (shift_ir) begin
      so_q <= ir_shift[0];
    end else if (shift_dr) begin
      so_q <= dr_so;
    end else begin
      so_q <= 1'b0;
    end
  end

  // zero-delay pass-through while excluded
  assign so = enable ? so_q : si;

endmodule

`default_nettype wire

// File: src/tap_controller.sv
// ==============================
// ieee 1149.1 tap state machine with decoded phase strobes
// one instance per tap, hold_reset parks it in test-logic-reset
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tap_controller (
  input  wire logic            tck,
  input  wire logic            rst_n,
  input  wire logic            tms,
  input  wire logic            hold_reset,
  output tapnw_pkg::tap_state_e state,
  output logic                 capture_ir,
  output logic                 shift_ir,
  output logic                 update_ir,
  output logic                 capture_dr,
  output logic                 shift_dr,
  output logic                 update_dr,
  output logic                 test_reset
);

  tapnw_pkg::tap_state_e next_state;

  // ==============================
  // state graph
  // ==============================
  always_comb begin
    next_state = state;
    case (state)
      tapnw_pkg::TEST_LOGIC_RESET:
        next_state = tms ? tapnw_pkg::TEST_LOGIC_RESET : tapnw_pkg::RUN_TEST_IDLE;
      tapnw_pkg::RUN_TEST_IDLE:
        next_state = tms ? tapnw_pkg::SELECT_DR_SCAN : tapnw_pkg::RUN_TEST_IDLE;
      // dr column
      tapnw_pkg::SELECT_DR_SCAN:
        next_state = tms ? tapnw_pkg::SELECT_IR_SCAN : tapnw_pkg::CAPTURE_DR;
      tapnw_pkg::CAPTURE_DR:
        next_state = tms ? tapnw_pkg::EXIT1_DR : tapnw_pkg::SHIFT_DR;
      tapnw_pkg::SHIFT_DR:
        next_state = tms ? tapnw_pkg::EXIT1_DR : tapnw_pkg::SHIFT_DR;
      tapnw_pkg::EXIT1_DR:
        next_state = tms ? tapnw_pkg::UPDATE_DR : tapnw_pkg::PAUSE_DR;
      tapnw_pkg::PAUSE_DR:
        next_state = tms ? tapnw_pkg::EXIT2_DR : tapnw_pkg::PAUSE_DR;
      tapnw_pkg::EXIT2_DR:
        next_state = tms ? tapnw_pkg::UPDATE_DR : tapnw_pkg::SHIFT_DR;
      tapnw_pkg::UPDATE_DR:
        next_state = tms ? tapnw_pkg::SELECT_DR_SCAN : tapnw_pkg::RUN_TEST_IDLE;
      // ir column, select-ir with tms high escapes to reset
      tapnw_pkg::SELECT_IR_SCAN:
        next_state = tms ? tapnw_pkg::TEST_LOGIC_RESET : tapnw_pkg::CAPTURE_IR;
      tapnw_pkg::CAPTURE_IR:
        next_state = tms ? tapnw_pkg::EXIT1_IR : tapnw_pkg::SHIFT_IR;
      tapnw_pkg::SHIFT_IR:
        next_state = tms ? tapnw_pkg::EXIT1_IR : tapnw_pkg::SHIFT_IR;
      tapnw_pkg::EXIT1_IR:
        next_state = tms ? tapnw_pkg::UPDATE_IR : tapnw_pkg::PAUSE_IR;
      tapnw_pkg::PAUSE_IR:
        next_state = tms ? tapnw_pkg::EXIT2_IR : tapnw_pkg::PAUSE_IR;
      tapnw_pkg::EXIT2_IR:
        next_state = tms ? tapnw_pkg::UPDATE_IR : tapnw_pkg::SHIFT_IR;
      tapnw_pkg::UPDATE_IR:
        next_state = tms ? tapnw_pkg::SELECT_DR_SCAN : tapnw_pkg::RUN_TEST_IDLE;
      default:
        next_state = tapnw_pkg::TEST_LOGIC_RESET;
    endcase
  end

  // hold_reset wins over tms while the tap is excluded
  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      state <= tapnw_pkg::TEST_LOGIC_RESET;
    end else if (hold_reset) begin
      state <= tapnw_pkg::TEST_LOGIC_RESET;
    end else begin
      state <= next_state;
    end
  end

  // ==============================
  // phase strobes
  // ==============================
  // each strobe acts on the rising edge that leaves its state
  assign capture_ir = (state == tapnw_pkg::CAPTURE_IR);
  assign shift_ir   = (state == tapnw_pkg::SHIFT_IR);
  assign update_ir  = (state == tapnw_pkg::UPDATE_IR);
  assign capture_dr = (state == tapnw_pkg::CAPTURE_DR);
  assign shift_dr   = (state == tapnw_pkg::SHIFT_DR);
  assign update_dr  = (state == tapnw_pkg::UPDATE_DR);
  assign test_reset = (state == tapnw_pkg::TEST_LOGIC_RESET);

endmodule

`default_nettype wire

// File: src/tap_data_reg.sv
// ==============================
// capture / shift / update data register for any packed payload
// holds the master select register and each slave user register
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tap_data_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  wire logic tck,
  input  wire logic rst_n,
  input  wire logic clear,
  input  wire logic capture,
  input  wire logic shift,
  input  wire logic update,
  input  wire logic si,
  output logic      so,
  output payload_t  value
);

  localparam int W = $bits(payload_t);

  // shift stage, lsb goes out first
  logic [W-1:0] shift_q;

  always_ff @(posedge tck or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '0;
      value   <= payload_t'('0);
    end else if (clear) begin
      // test-logic-reset zeroes both stages
      shift_q <= '0;
      value   <= payload_t'('0);
    end else begin
      // readback path, capture loads the current update value
      if (capture) begin
        shift_q <= value;
      end else if (shift) begin
        // new bit enters at the msb
        shift_q <= {si, shift_q[W-1:1]};
      end
      // update stage only moves on leaving update-dr
      if (update) begin
        value <= payload_t'(shift_q);
      end
    end
  end

  // unregistered here, the tap launches it on the falling edge
  assign so = shift_q[0];

endmodule

`default_nettype wire

// File: src/tapnw_pkg.sv
// ==============================
// shared opcodes, widths, idcodes and payload types for the jtag tap network
// referenced by scoped name from every tap module
// ==============================
`default_nettype none

package tapnw_pkg;

  // ==============================
  // network shape
  // ==============================
  // slave taps behind the master
  localparam int NUM_SLAVES = 3;
  // same ir length on every tap
  localparam int IR_LEN = 4;

  // ir payload
  typedef logic [IR_LEN-1:0] ir_t;
  // one enable bit per slave, bit i is slave i
  typedef logic [NUM_SLAVES-1:0] sel_t;
  // slave user data payload
  typedef logic [7:0] user_t;

  // ==============================
  // instructions
  // ==============================
  localparam ir_t OP_IDCODE = 4'h1;
  // master only
  localparam ir_t OP_SELECT = 4'h2;
  // slaves only
  localparam ir_t OP_USER   = 4'h3;
  // any opcode not decoded falls back to bypass
  localparam ir_t OP_BYPASS = 4'hf;

  // fixed capture-ir pattern, lsb set as 1149.1 requires
  localparam ir_t IR_CAPTURE = 4'b0001;

  // identification codes, bit 0 always set
  localparam logic [31:0] MASTER_IDCODE = 32'h1a5c_3015;
  // indexed by slave position on the chain
  localparam logic [31:0] SLAVE_IDCODE [NUM_SLAVES] = '{
    32'h2b10_0035,
    32'h2b11_0035,
    32'h2b12_0035
  };

  // standard 1149.1 state encoding
  typedef enum logic [3:0] {
    EXIT2_DR         = 4'h0,
    EXIT1_DR         = 4'h1,
    SHIFT_DR         = 4'h2,
    PAUSE_DR         = 4'h3,
    SELECT_IR_SCAN   = 4'h4,
    UPDATE_DR        = 4'h5,
    CAPTURE_DR       = 4'h6,
    SELECT_DR_SCAN   = 4'h7,
    EXIT2_IR         = 4'h8,
    EXIT1_IR         = 4'h9,
    SHIFT_IR         = 4'ha,
    PAUSE_IR         = 4'hb,
    RUN_TEST_IDLE    = 4'hc,
    UPDATE_IR        = 4'hd,
    CAPTURE_IR       = 4'he,
    TEST_LOGIC_RESET = 4'hf
  } tap_state_e;

endpackage

`default_nettype wire

// File: src/tapnw_top.sv
// ==============================
// tap network top, master first then slaves 0..2 on one serial chain
// tdi enters the master, the last slave drives tdo
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tapnw_top (
  input  wire logic tck,
  input  wire logic rst_n,
  input  wire logic tms,
  input  wire logic tdi,
  output logic      tdo,
  output logic      tdo_en
);

  // chain[0] is the master output, chain[i+1] is slave i output
  logic [tapnw_pkg::NUM_SLAVES:0] chain;
  tapnw_pkg::sel_t                slave_enable;

  // ==============================
  // master
  // ==============================
  // its shifting flag doubles as the network tdo enable
  master_tap u_master (
    .tck          (tck),
    .rst_n        (rst_n),
    .tms          (tms),
    .tdi          (tdi),
    .so           (chain[0]),
    .shifting     (tdo_en),
    .slave_enable (slave_enable)
  );

  // ==============================
  // slaves
  // ==============================
  // all share tms, excluded ones ignore it
  for (genvar i = 0; i < tapnw_pkg::NUM_SLAVES; i++) begin : gen_slave
    slave_tap #(
      .tap_index (i)
    ) u_slave (
      .tck    (tck),
      .rst_n  (rst_n),
      .tms    (tms),
      .enable (slave_enable[i]),
      .si     (chain[i]),
      .so     (chain[i+1])
    );
  end

  // already low outside shift, every tap zeroes its output there
  assign tdo = chain[tapnw_pkg::NUM_SLAVES];

endmodule

`default_nettype wire

// File: tapnw.f
src/tapnw_pkg.sv
src/tap_controller.sv
src/tap_data_reg.sv
src/master_tap.sv
src/slave_tap.sv
src/tapnw_top.sv
bench/tapnw_assertions.sv
bench/tapnw_tb.sv
